//--- compile.f
hw/rv_isa_pkg.sv
hw/exec_pkg.sv
hw/alu.sv
hw/divu_remu.sv
hw/alu_ext.sv
hw/exec_unit.sv
sim/exec_unit_assert.sv
sim/exec_unit_tb.sv

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                 order,
    output logic                 accepted,
    output logic                 done,
    input  exec_pkg::exec_req_t  req,
    output rv_isa_pkg::word_t    rd,
    input  logic                 clk,
    input  logic                 rst
);
    import rv_isa_pkg::*;

    logic   mode;
    shamt_t shamt;
    word_t  calc_rd;
    word_t  rd_hold;

    // single cycle, never stalls
    assign accepted = order;
    assign done     = order;

    assign mode  = req.func7[FUNC7_MODE_BIT];
    assign shamt = req.rs2[LEN_SHAMT-1:0];

    always_comb begin
        case (req.func3)
            FUNC3_ADD: begin
                calc_rd = mode ? (req.rs1 - req.rs2) : (req.rs1 + req.rs2);
            end
            FUNC3_SL: begin
                calc_rd = req.rs1 << shamt;
            end
            FUNC3_SLT: begin
                calc_rd = {{(LEN_WORD-1){1'b0}}, $signed(req.rs1) < $signed(req.rs2)};
            end
            FUNC3_SLTU: begin
                calc_rd = {{(LEN_WORD-1){1'b0}}, req.rs1 < req.rs2};
            end
            FUNC3_XOR: begin
                calc_rd = req.rs1 ^ req.rs2;
            end
            FUNC3_SR: begin
                // arithmetic shift keeps the sign bit
                calc_rd = mode ? word_t'($signed(req.rs1) >>> shamt) : (req.rs1 >> shamt);
            end
            FUNC3_OR: begin
                calc_rd = req.rs1 | req.rs2;
            end
            FUNC3_AND: begin
                calc_rd = req.rs1 & req.rs2;
            end
            default: begin
                calc_rd = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hold <= '0;
        end else if (done) begin
            rd_hold <= calc_rd;
        end
    end

    // fresh result in the done cycle, held value after
    assign rd = done ? calc_rd : rd_hold;

endmodule

//--- hw/alu_ext.sv
`timescale 1ns/1ps

module alu_ext (
    input  logic                order,
    output logic                accepted,
    output logic                done,
    input  exec_pkg::exec_req_t req,
    output rv_isa_pkg::word_t   rd,
    input  logic                clk,
    input  logic                rst
);
    import rv_isa_pkg::*;

    logic  busy;
    logic  order_able;
    logic  is_div;
    logic  want_rem;

    logic  div_order;
    logic  div_accepted;
    logic  div_done;
    word_t div_rd;

    logic  err_order;
    word_t next_rd;
    word_t rd_hold;

    // one extension order at a time
    assign order_able = order & ~busy;

    assign is_div   = (req.func3 == FUNC3_DIVU) | (req.func3 == FUNC3_REMU);
    assign want_rem = (req.func3 == FUNC3_REMU);

    assign div_order = order_able & is_div;

    divu_remu divu_remu_inst (
        .order    (div_order),
        .accepted (div_accepted),
        .done     (div_done),
        .dividend (req.rs1),
        .divisor  (req.rs2),
        .want_rem (want_rem),
        .rd       (div_rd),
        .clk      (clk),
        .rst      (rst)
    );

    // unsupported M codes finish at once with zero
    assign err_order = order_able & ~is_div;

    assign accepted = div_accepted | err_order;
    assign done     = div_done | err_order;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (div_accepted) begin
            busy <= 1'b1;
        end else if (div_done) begin
            busy <= 1'b0;
        end
    end

    assign next_rd = div_done  ? div_rd :
                     err_order ? '0     :
                                 rd_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hold <= '0;
        end else if (done) begin
            rd_hold <= next_rd;
        end
    end

    assign rd = next_rd;

endmodule

//--- hw/divu_remu.sv
`timescale 1ns/1ps

module divu_remu (
    input  logic              order,
    output logic              accepted,
    output logic              done,
    input  rv_isa_pkg::word_t dividend,
    input  rv_isa_pkg::word_t divisor,
    input  logic              want_rem,
    output rv_isa_pkg::word_t rd,
    input  logic              clk,
    input  logic              rst
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic       busy;
    div_count_t count;

    word_t rem_q;
    word_t quo_q;
    word_t divisor_q;
    logic  want_rem_q;

    logic [LEN_WORD:0] rem_shift;
    logic [LEN_WORD:0] rem_diff;
    logic              fits;
    word_t             rem_next;
    word_t             quo_next;
    word_t             result;
    word_t             rd_hold;

    assign accepted = order & ~busy;

    // the last step is finished combinationally in the done cycle
    assign done = busy & (count == div_count_t'(DIV_STEPS - 1));

    // shift in the next dividend bit and try to subtract
    assign rem_shift = {rem_q, quo_q[LEN_WORD-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};
    assign fits      = ~rem_diff[LEN_WORD];

    assign rem_next = fits ? rem_diff[LEN_WORD-1:0] : rem_shift[LEN_WORD-1:0];
    assign quo_next = {quo_q[LEN_WORD-2:0], fits};

    // a zero divisor always fits, so quotient is all ones and rem is the dividend
    assign result = want_rem_q ? rem_next : quo_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else begin
            if (accepted) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (done) begin
                busy <= 1'b0;
            end else if (busy) begin
                count <= count + 1'b1;
            end
        end
    end

    // quotient register starts as the dividend and fills from the right
    always_ff @(posedge clk) begin
        if (accepted) begin
            rem_q      <= '0;
            quo_q      <= dividend;
            divisor_q  <= divisor;
            want_rem_q <= want_rem;
        end else if (busy) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hold <= '0;
        end else if (done) begin
            rd_hold <= result;
        end
    end

    assign rd = done ? result : rd_hold;

endmodule

//--- hw/exec_pkg.sv
package exec_pkg;

    // one order as seen by every execute unit
    typedef struct packed {
        rv_isa_pkg::func3_t func3;
        rv_isa_pkg::func7_t func7;
        rv_isa_pkg::word_t  rs1;
        rv_isa_pkg::word_t  rs2;
    } exec_req_t;

    // strobes and result of one unit
    typedef struct packed {
        logic              accepted;
        logic              done;
        rv_isa_pkg::word_t rd;
    } exec_rsp_t;

    // unit whose result is on rd
    typedef enum logic {
        SRC_ALU,
        SRC_EXT
    } exec_src_t;

    // one quotient bit per step
    localparam int DIV_STEPS     = 32;
    localparam int LEN_DIV_COUNT = 6;

    typedef logic [LEN_DIV_COUNT-1:0] div_count_t;

endpackage

//--- hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                order,
    output logic                accepted,
    output logic                done,
    input  exec_pkg::exec_req_t req,
    output rv_isa_pkg::word_t   rd,
    input  logic                clk,
    input  logic                rst
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic      is_ext;
    logic      alu_order;
    logic      ext_order;
    exec_src_t last_src;
    exec_src_t sel_src;

    wire exec_rsp_t alu_rsp;
    wire exec_rsp_t ext_rsp;

    // route by func7
    assign is_ext    = (req.func7 == FUNC7_MULDIV);
    assign ext_order = order & is_ext;

    // base order waits a cycle when a divide completes
    assign alu_order = order & ~is_ext & ~ext_rsp.done;

    alu alu_inst (
        .order    (alu_order),
        .accepted (alu_rsp.accepted),
        .done     (alu_rsp.done),
        .req      (req),
        .rd       (alu_rsp.rd),
        .clk      (clk),
        .rst      (rst)
    );

    alu_ext alu_ext_inst (
        .order    (ext_order),
        .accepted (ext_rsp.accepted),
        .done     (ext_rsp.done),
        .req      (req),
        .rd       (ext_rsp.rd),
        .clk      (clk),
        .rst      (rst)
    );

    assign accepted = alu_rsp.accepted | ext_rsp.accepted;
    assign done     = alu_rsp.done | ext_rsp.done;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_src <= SRC_ALU;
        end else if (ext_rsp.done) begin
            last_src <= SRC_EXT;
        end else if (alu_rsp.done) begin
            last_src <= SRC_ALU;
        end
    end

    // each unit keeps its own result, so only the source has to be chosen
    assign sel_src = ext_rsp.done ? SRC_EXT :
                     alu_rsp.done ? SRC_ALU :
                                    last_src;

    assign rd = (sel_src == SRC_EXT) ? ext_rsp.rd : alu_rsp.rd;

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // base widths of the integer ISA
    localparam int LEN_WORD  = 32;
    localparam int LEN_FUNC3 = 3;
    localparam int LEN_FUNC7 = 7;
    localparam int LEN_SHAMT = 5;

    typedef logic [LEN_WORD-1:0]  word_t;
    typedef logic [LEN_FUNC3-1:0] func3_t;
    typedef logic [LEN_FUNC7-1:0] func7_t;
    typedef logic [LEN_SHAMT-1:0] shamt_t;

    // RV32I register-register func3 codes
    localparam func3_t FUNC3_ADD  = 3'b000;
    localparam func3_t FUNC3_SL   = 3'b001;
    localparam func3_t FUNC3_SLT  = 3'b010;
    localparam func3_t FUNC3_SLTU = 3'b011;
    localparam func3_t FUNC3_XOR  = 3'b100;
    localparam func3_t FUNC3_SR   = 3'b101;
    localparam func3_t FUNC3_OR   = 3'b110;
    localparam func3_t FUNC3_AND  = 3'b111;

    // M extension codes handled by the divider
    localparam func3_t FUNC3_DIVU = 3'b101;
    localparam func3_t FUNC3_REMU = 3'b111;

    // sub / sra select inside func7
    localparam int FUNC7_MODE_BIT = 5;

    // func7 of every M extension instruction
    localparam func7_t FUNC7_MULDIV = 7'b0000001;

endpackage

//--- sim/exec_unit_assert.sv
`timescale 1ns/1ps

module exec_unit_sva (
    input logic clk,
    input logic rst,
    input logic order,
    input logic accepted,
    input logic done,
    input logic busy
);

    int fail_count = 0;

    // completion is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for two consecutive cycles");
        end

    accept_needs_order: assert property (@(posedge clk) disable iff (rst) accepted |-> order)
        else begin
            fail_count++;
            $error("accepted was high without order");
        end

    // a running divide blocks new extension orders
    no_accept_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !accepted)
        else begin
            fail_count++;
            $error("accepted was high while the unit was busy");
        end

endmodule

bind exec_unit exec_unit_sva exec_unit_sva_inst (
    .clk      (clk),
    .rst      (rst),
    .order    (order),
    .accepted (accepted),
    .done     (done),
    .busy     (1'b0)
);

bind alu_ext exec_unit_sva alu_ext_sva_inst (
    .clk      (clk),
    .rst      (rst),
    .order    (order),
    .accepted (accepted),
    .done     (done),
    .busy     (busy)
);

//--- sim/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;
    import rv_isa_pkg::*;
    import exec_pkg::*;

    // one table entry with its name kept in a parallel queue
    typedef struct packed {
        exec_req_t req;
        word_t     exp;
        logic      rnd;
    } row_t;

    logic      clk;
    logic      rst;
    logic      order;
    logic      accepted;
    logic      done;
    exec_req_t req;
    word_t     rd;

    row_t   rows[$];
    string  names[$];
    integer seed;
    int     cycle = 0;
    logic   table_ready = 1'b0;

    exec_unit exec_unit_inst (
        .order    (order),
        .accepted (accepted),
        .done     (done),
        .req      (req),
        .rd       (rd),
        .clk      (clk),
        .rst      (rst)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic exec_req_t make_req(input func3_t f3, input func7_t f7,
                                           input word_t a, input word_t b);
        exec_req_t r;
        r.func3 = f3;
        r.func7 = f7;
        r.rs1   = a;
        r.rs2   = b;
        return r;
    endfunction

    function automatic void add_row(input string name, input func3_t f3, input func7_t f7,
                                    input word_t a, input word_t b, input word_t exp,
                                    input logic rnd);
        row_t r;
        r.req = make_req(f3, f7, a, b);
        r.exp = exp;
        r.rnd = rnd;
        rows.push_back(r);
        names.push_back(name);
    endfunction

    // unsigned division as the ISA defines it including a zero divisor
    function automatic word_t expected_div(input exec_req_t r);
        if (r.rs2 == 32'h0) begin
            return (r.func3 == FUNC3_REMU) ? r.rs1 : 32'hffff_ffff;
        end
        return (r.func3 == FUNC3_REMU) ? (r.rs1 % r.rs2) : (r.rs1 / r.rs2);
    endfunction

    function automatic int expected_latency(input exec_req_t r);
        if (r.func7 == FUNC7_MULDIV && (r.func3 == FUNC3_DIVU || r.func3 == FUNC3_REMU)) begin
            return DIV_STEPS;
        end
        return 0;
    endfunction

    // failures counted by the bound protocol checkers
    function automatic int protocol_failures();
        return exec_unit_inst.exec_unit_sva_inst.fail_count
             + exec_unit_inst.alu_ext_inst.alu_ext_sva_inst.fail_count;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h",
                                     name, exp, act));
        end
    endtask

    task automatic check_strobe(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("FAILED %s latency: expected %0d, actual %0d",
                                     name, exp, act));
        end
    endtask

    // raise order and hold it until the DUT takes it
    task automatic issue(input exec_req_t r, output int acc_cycle);
        @(posedge clk);
        #1;
        order = 1'b1;
        req   = r;
        @(negedge clk);
        while (!accepted) begin
            @(negedge clk);
        end
        acc_cycle = cycle;
    endtask

    task automatic finish_order(input string name, input word_t exp, input int lat,
                                input int acc_cycle);
        while (!done) begin
            @(posedge clk);
            #1 order = 1'b0;
            @(negedge clk);
        end
        check_latency(name, lat, cycle - acc_cycle);
        check_word(name, exp, rd);
        @(posedge clk);
        #1 order = 1'b0;
        // rd must stay put over idle cycles
        repeat (3) begin
            @(negedge clk);
            check_strobe({name, " idle done"}, 1'b0, done);
            check_word({name, " hold"}, exp, rd);
        end
    endtask

    task automatic busy_divider();
        exec_req_t div_req;
        exec_req_t rem_req;
        exec_req_t base_req;
        int        acc_cycle;
        int        base_cycle;
        logic      div_seen;
        div_req  = make_req(FUNC3_DIVU, FUNC7_MULDIV, 32'd1000, 32'd9);
        rem_req  = make_req(FUNC3_REMU, FUNC7_MULDIV, 32'd1000, 32'd9);
        base_req = make_req(FUNC3_XOR, 7'h00, 32'h1234_5678, 32'hffff_0000);
        issue(div_req, acc_cycle);
        @(posedge clk);
        #1 order = 1'b0;
        // a base order slips past the running divide
        issue(base_req, base_cycle);
        check_strobe("busy base done", 1'b1, done);
        check_word("busy base", 32'hedcb_5678, rd);
        @(posedge clk);
        #1 order = 1'b0;
        @(posedge clk);
        #1;
        order    = 1'b1;
        req      = rem_req;
        div_seen = 1'b0;
        @(negedge clk);
        while (!accepted) begin
            if (done) begin
                check_latency("busy divu", DIV_STEPS, cycle - acc_cycle);
                check_word("busy divu", 32'd111, rd);
                div_seen = 1'b1;
            end
            @(negedge clk);
        end
        check_strobe("busy remu waits for divu done", 1'b1, div_seen);
        finish_order("busy remu", 32'd1, DIV_STEPS, cycle);
    endtask

    task automatic build_table();
        add_row("add",        FUNC3_ADD,  7'h00, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 0);
        add_row("add_wrap",   FUNC3_ADD,  7'h00, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 0);
        add_row("sub",        FUNC3_ADD,  7'h20, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 0);
        add_row("sll",        FUNC3_SL,   7'h00, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010, 0);
        add_row("srl",        FUNC3_SR,   7'h00, 32'h8000_0000, 32'h0000_0021, 32'h4000_0000, 0);
        add_row("sra",        FUNC3_SR,   7'h20, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 0);
        add_row("xor",        FUNC3_XOR,  7'h00, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hff00_ff00, 0);
        add_row("or",         FUNC3_OR,   7'h00, 32'hf000_000f, 32'h0000_0f00, 32'hf000_0f0f, 0);
        add_row("and",        FUNC3_AND,  7'h00, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 0);
        // mixed signs split signed and unsigned compares
        add_row("slt_neg",    FUNC3_SLT,  7'h00, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 0);
        add_row("sltu_neg",   FUNC3_SLTU, 7'h00, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 0);
        add_row("slt_pos",    FUNC3_SLT,  7'h00, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0000, 0);
        add_row("sltu_pos",   FUNC3_SLTU, 7'h00, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, 0);
        add_row("divu",       FUNC3_DIVU, FUNC7_MULDIV, 32'd100, 32'd7, 32'd14, 0);
        add_row("remu",       FUNC3_REMU, FUNC7_MULDIV, 32'd100, 32'd7, 32'd2, 0);
        add_row("divu_big",   FUNC3_DIVU, FUNC7_MULDIV, 32'hffff_ffff, 32'h10, 32'h0fff_ffff, 0);
        add_row("remu_big",   FUNC3_REMU, FUNC7_MULDIV, 32'hffff_ffff, 32'h10, 32'h0000_000f, 0);
        add_row("divu_small", FUNC3_DIVU, FUNC7_MULDIV, 32'd3, 32'd5, 32'd0, 0);
        add_row("remu_small", FUNC3_REMU, FUNC7_MULDIV, 32'd3, 32'd5, 32'd3, 0);
        add_row("divu_zero",  FUNC3_DIVU, FUNC7_MULDIV, 32'h1234_5678, 32'h0, 32'hffff_ffff, 0);
        add_row("remu_zero",  FUNC3_REMU, FUNC7_MULDIV, 32'h1234_5678, 32'h0, 32'h1234_5678, 0);
        add_row("ext_f0",     3'b000, FUNC7_MULDIV, 32'h0000_0003, 32'h0000_0004, 32'h0, 0);
        add_row("ext_f3",     3'b011, FUNC7_MULDIV, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 0);
        add_row("ext_f4",     3'b100, FUNC7_MULDIV, 32'd100, 32'd7, 32'h0, 0);
        add_row("ext_f6",     3'b110, FUNC7_MULDIV, 32'd100, 32'd7, 32'h0, 0);
        for (int i = 0; i < 8; i++) begin
            add_row($sformatf("rand_%s_%0d", (i % 2) ? "remu" : "divu", i),
                    (i % 2) ? FUNC3_REMU : FUNC3_DIVU, FUNC7_MULDIV, 32'h0, 32'h0, 32'h0, 1);
        end
    endtask

    initial begin
        row_t r;
        int   acc_cycle;
        seed   = 63;
        order  = 1'b0;
        req    = '0;
        rst    = 1'b1;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_strobe("reset accepted", 1'b0, accepted);
        check_strobe("reset done", 1'b0, done);
        check_word("reset rd", 32'h0, rd);
        foreach (rows[i]) begin
            r = rows[i];
            if (r.rnd) begin
                r.req.rs1 = $random(seed);
                r.req.rs2 = $random(seed) & 32'h0000_ffff;
                r.exp     = expected_div(r.req);
            end
            issue(r.req, acc_cycle);
            finish_order(names[i], r.exp, expected_latency(r.req), acc_cycle);
        end
        busy_divider();
        if (protocol_failures() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("a bound protocol assertion failed");
        end
    end

    // stop at the first protocol violation seen by the bound checkers
    always @(negedge clk) begin
        if (protocol_failures() != 0) begin
            report_failure("a bound protocol assertion failed");
        end
    end

    // budget covers every row as a divide plus the busy sequence
    initial begin
        int limit;
        wait (table_ready);
        limit = 16 + (rows.size() + 4) * (DIV_STEPS + 8);
        repeat (limit) @(posedge clk);
        report_failure($sformatf("timeout: the run did not finish within %0d cycles", limit));
    end

endmodule
